/* avl_master.sv */
`timescale 1ns/1ps
`include "i2c_avl_defs.svh"

module avl_master (
  input  logic                   clk,
  input  logic                   arst_n,
  input  i2c_avl_pkg::rx_byte_t  rx,
  input  logic                   rd_req,
  input  i2c_avl_pkg::avl_data_t readdata,
  input  logic                   readdatavalid,
  input  logic                   waitrequest,
  output i2c_avl_pkg::avl_cmd_t  cmd,
  output i2c_avl_pkg::tx_byte_t  tx,
  output logic                   busy
);

  localparam int CW = $clog2(`I2C_ADDR_BYTES + 1);

  i2c_avl_pkg::avl_addr_t addr;
  i2c_avl_pkg::avl_data_t wdata;
  i2c_avl_pkg::avl_be_t   be;
  logic [CW-1:0]          byte_cnt;
  logic                   wr;
  logic                   rd;
  logic                   rd_wait;    // read accepted, data not back yet
  logic                   addr_byte;
  logic                   wr_done;
  logic                   rd_accept;
  logic                   rd_done;

  assign addr_byte = byte_cnt < CW'(`I2C_ADDR_BYTES);
  assign wr_done   = wr & ~waitrequest;
  assign rd_accept = rd & ~waitrequest;
  assign rd_done   = readdatavalid & (rd_wait | rd_accept);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      addr     <= '0;
      byte_cnt <= '0;
      wr       <= 1'b0;
      rd       <= 1'b0;
      rd_wait  <= 1'b0;
      tx       <= '0;
    end else begin
      tx.valid <= 1'b0;

      if (rx.valid) begin
        if (rx.first) begin
          addr     <= i2c_avl_pkg::avl_addr_t'(rx.data);   // new address phase
          byte_cnt <= CW'(1);
        end else if (addr_byte) begin
          addr     <= {addr[`AVL_AW-9:0], rx.data};
          byte_cnt <= byte_cnt + 1'b1;
        end else begin
          wr <= 1'b1;
        end
      end

      if (wr_done) begin
        wr   <= 1'b0;
        addr <= addr + 1'b1;
      end

      if (rd_req) begin
        rd <= 1'b1;
      end
      if (rd_accept) begin
        rd      <= 1'b0;
        rd_wait <= 1'b1;
      end
      if (rd_done) begin
        rd_wait  <= 1'b0;
        tx.valid <= 1'b1;
        tx.data  <= readdata[{addr[1:0], 3'b000} +: 8];
        addr     <= addr + 1'b1;
      end
    end
  end

  // write payload, byte copied to every lane
  always_ff @(posedge clk) begin
    if (rx.valid) begin
      wdata <= {(`AVL_DW / 8){rx.data}};
      be    <= i2c_avl_pkg::avl_be_t'(1) << addr[1:0];
    end
  end

  always_comb begin
    cmd.address    = {addr[`AVL_AW-1:2], 2'b00};   // word aligned, lane in byteenable
    cmd.read       = rd;
    cmd.write      = wr;
    cmd.writedata  = wdata;
    cmd.byteenable = be;
  end

  assign busy = wr;

endmodule

/* i2c_avl_bridge.sv */
`timescale 1ns/1ps

module i2c_avl_bridge (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   i2c_data_in,
  input  logic                   i2c_clk_in,
  output logic                   i2c_data_oe,   // 1 pulls sda low
  output logic                   i2c_clk_oe,    // 1 pulls scl low
  output i2c_avl_pkg::avl_addr_t address,
  output logic                   read,
  output logic                   write,
  output i2c_avl_pkg::avl_data_t writedata,
  output i2c_avl_pkg::avl_be_t   byteenable,
  input  i2c_avl_pkg::avl_data_t readdata,
  input  logic                   readdatavalid,
  input  logic                   waitrequest
);

  i2c_avl_pkg::line_evt_t evt;
  i2c_avl_pkg::rx_byte_t  rx;
  i2c_avl_pkg::tx_byte_t  tx;
  i2c_avl_pkg::avl_cmd_t  cmd;
  logic                   rd_req;
  logic                   busy;
  logic                   sda_oe;
  logic                   scl_oe;

  i2c_line_filter u_line_filter (
    .clk         (clk),
    .arst_n      (arst_n),
    .i2c_data_in (i2c_data_in),
    .i2c_clk_in  (i2c_clk_in),
    .evt         (evt)
  );

  i2c_slave_fsm u_slave_fsm (
    .clk    (clk),
    .arst_n (arst_n),
    .evt    (evt),
    .tx     (tx),
    .busy   (busy),
    .rx     (rx),
    .rd_req (rd_req),
    .sda_oe (sda_oe),
    .scl_oe (scl_oe)
  );

  avl_master u_avl_master (
    .clk           (clk),
    .arst_n        (arst_n),
    .rx            (rx),
    .rd_req        (rd_req),
    .readdata      (readdata),
    .readdatavalid (readdatavalid),
    .waitrequest   (waitrequest),
    .cmd           (cmd),
    .tx            (tx),
    .busy          (busy)
  );

  assign address     = cmd.address;
  assign read        = cmd.read;
  assign write       = cmd.write;
  assign writedata   = cmd.writedata;
  assign byteenable  = cmd.byteenable;
  assign i2c_data_oe = sda_oe;
  assign i2c_clk_oe  = scl_oe;

endmodule

/* i2c_avl_defs.svh */
`ifndef I2C_AVL_DEFS_SVH
`define I2C_AVL_DEFS_SVH

// 7-bit slave address answered on the bus
`define I2C_SLAVE_ADDR 7'h55

// address bytes after a write header, msb first
`define I2C_ADDR_BYTES 2

// equal samples needed before a filtered line moves
`define I2C_SPKLEN 2

// avalon-mm master widths
`define AVL_AW 32
`define AVL_DW 32
`define AVL_BEW 4

`endif

/* i2c_avl_pkg.sv */
`include "i2c_avl_defs.svh"

package i2c_avl_pkg;

  typedef logic [7:0]          i2c_byte_t;
  typedef logic [`AVL_AW-1:0]  avl_addr_t;   // byte address
  typedef logic [`AVL_DW-1:0]  avl_data_t;
  typedef logic [`AVL_BEW-1:0] avl_be_t;

  // filtered levels plus one-cycle event pulses
  typedef struct packed {
    logic scl;
    logic sda;
    logic scl_rise;
    logic scl_fall;
    logic start;
    logic stop;
  } line_evt_t;

  typedef struct packed {
    logic      valid;
    logic      first;   // first byte after a write header
    i2c_byte_t data;
  } rx_byte_t;

  typedef struct packed {
    logic      valid;
    i2c_byte_t data;
  } tx_byte_t;

  typedef struct packed {
    avl_addr_t address;
    logic      read;
    logic      write;
    avl_data_t writedata;
    avl_be_t   byteenable;
  } avl_cmd_t;

  typedef enum logic [2:0] {
    IDLE, ADDR, ADDR_ACK, RX_BYTE, RX_ACK, TX_LOAD, TX_BYTE, TX_ACK
  } slv_state_t;

endpackage

/* i2c_line_filter.sv */
`timescale 1ns/1ps
`include "i2c_avl_defs.svh"

module i2c_line_filter (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   i2c_data_in,
  input  logic                   i2c_clk_in,
  output i2c_avl_pkg::line_evt_t evt
);

  localparam int CW = $clog2(`I2C_SPKLEN + 1);

  // index 0 is scl, index 1 is sda
  logic [1:0]    pin;
  logic [1:0]    sync1;
  logic [1:0]    sync2;
  logic [1:0]    filt;
  logic [1:0]    filt_q;
  logic [CW-1:0] cnt [2];

  assign pin = {i2c_data_in, i2c_clk_in};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync1  <= 2'b11;   // idle bus is high
      sync2  <= 2'b11;
      filt   <= 2'b11;
      filt_q <= 2'b11;
      for (int i = 0; i < 2; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      sync1  <= pin;
      sync2  <= sync1;
      filt_q <= filt;
      for (int i = 0; i < 2; i++) begin
        if (sync2[i] == filt[i]) begin
          cnt[i] <= '0;
        end else if (cnt[i] == CW'(`I2C_SPKLEN - 1)) begin
          filt[i] <= sync2[i];   // new level held long enough
          cnt[i]  <= '0;
        end else begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    evt.scl      = filt[0];
    evt.sda      = filt[1];
    evt.scl_rise = filt[0] & ~filt_q[0];
    evt.scl_fall = ~filt[0] & filt_q[0];
    // sda moving while scl stays high
    evt.start    = filt[0] & filt_q[0] & filt_q[1] & ~filt[1];
    evt.stop     = filt[0] & filt_q[0] & ~filt_q[1] & filt[1];
  end

endmodule

/* i2c_slave_fsm.sv */
`timescale 1ns/1ps
`include "i2c_avl_defs.svh"

module i2c_slave_fsm (
  input  logic                   clk,
  input  logic                   arst_n,
  input  i2c_avl_pkg::line_evt_t evt,
  input  i2c_avl_pkg::tx_byte_t  tx,
  input  logic                   busy,
  output i2c_avl_pkg::rx_byte_t  rx,
  output logic                   rd_req,
  output logic                   sda_oe,
  output logic                   scl_oe
);

  i2c_avl_pkg::slv_state_t state;
  i2c_avl_pkg::i2c_byte_t  sh;
  i2c_avl_pkg::i2c_byte_t  sh_next;
  logic [2:0]              bit_cnt;
  logic                    last_bit;
  logic                    rw;           // header r/w bit
  logic                    first_pend;

  assign sh_next  = {sh[6:0], evt.sda};
  assign last_bit = (bit_cnt == 3'd7);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= i2c_avl_pkg::IDLE;
      sh         <= '0;
      bit_cnt    <= '0;
      rw         <= 1'b0;
      first_pend <= 1'b0;
      rx         <= '0;
      rd_req     <= 1'b0;
      sda_oe     <= 1'b0;
      scl_oe     <= 1'b0;
    end else begin
      rx.valid <= 1'b0;
      rd_req   <= 1'b0;
      if (evt.stop) begin
        state  <= i2c_avl_pkg::IDLE;
        sda_oe <= 1'b0;
        scl_oe <= 1'b0;
      end else if (evt.start) begin
        // start and repeated start alike, address register untouched
        state   <= i2c_avl_pkg::ADDR;
        bit_cnt <= '0;
        sda_oe  <= 1'b0;
        scl_oe  <= 1'b0;
      end else begin
        case (state)
          i2c_avl_pkg::ADDR: begin
            if (evt.scl_rise) begin
              sh      <= sh_next;
              bit_cnt <= bit_cnt + 1'b1;
              if (last_bit) begin
                rw <= evt.sda;
                if (sh[6:0] == `I2C_SLAVE_ADDR) begin
                  state <= i2c_avl_pkg::ADDR_ACK;
                end else begin
                  state <= i2c_avl_pkg::IDLE;   // not ours, sit out until start
                end
              end
            end
          end

          i2c_avl_pkg::ADDR_ACK: begin
            if (evt.scl_fall) begin
              if (!sda_oe) begin
                sda_oe <= 1'b1;   // ack bit
              end else if (rw) begin
                sda_oe <= 1'b0;
                scl_oe <= 1'b1;   // hold scl until the first byte is fetched
                rd_req <= 1'b1;
                state  <= i2c_avl_pkg::TX_LOAD;
              end else begin
                sda_oe     <= 1'b0;
                first_pend <= 1'b1;
                state      <= i2c_avl_pkg::RX_BYTE;
              end
            end
          end

          i2c_avl_pkg::RX_BYTE: begin
            if (evt.scl_rise) begin
              sh      <= sh_next;
              bit_cnt <= bit_cnt + 1'b1;
              if (last_bit) begin
                rx.valid   <= 1'b1;
                rx.first   <= first_pend;
                rx.data    <= sh_next;
                first_pend <= 1'b0;
                state      <= i2c_avl_pkg::RX_ACK;
              end
            end
          end

          i2c_avl_pkg::RX_ACK: begin
            if (scl_oe) begin
              if (!busy) begin   // bus write done, let the master go on
                scl_oe <= 1'b0;
                state  <= i2c_avl_pkg::RX_BYTE;
              end
            end else if (evt.scl_fall) begin
              if (!sda_oe) begin
                sda_oe <= 1'b1;
              end else begin
                sda_oe <= 1'b0;
                if (busy) begin
                  scl_oe <= 1'b1;
                end else begin
                  state <= i2c_avl_pkg::RX_BYTE;
                end
              end
            end
          end

          i2c_avl_pkg::TX_LOAD: begin
            if (tx.valid) begin
              sh      <= tx.data;
              sda_oe  <= ~tx.data[7];   // msb out while scl still low
              bit_cnt <= '0;
              scl_oe  <= 1'b0;
              state   <= i2c_avl_pkg::TX_BYTE;
            end
          end

          i2c_avl_pkg::TX_BYTE: begin
            if (evt.scl_fall) begin
              bit_cnt <= bit_cnt + 1'b1;
              if (last_bit) begin
                sda_oe <= 1'b0;   // free sda for the master ack
                state  <= i2c_avl_pkg::TX_ACK;
              end else begin
                sh     <= {sh[6:0], 1'b0};
                sda_oe <= ~sh[6];
              end
            end
          end

          i2c_avl_pkg::TX_ACK: begin
            if (evt.scl_rise && evt.sda) begin
              state <= i2c_avl_pkg::IDLE;   // nack ends the read
            end else if (evt.scl_fall) begin
              rd_req <= 1'b1;
              scl_oe <= 1'b1;
              state  <= i2c_avl_pkg::TX_LOAD;
            end
          end

          default: begin
            state <= i2c_avl_pkg::IDLE;
          end
        endcase
      end
    end
  end

endmodule

/* tb.f */
+incdir+.
i2c_avl_pkg.sv
i2c_line_filter.sv
i2c_slave_fsm.sv
avl_master.sv
i2c_avl_bridge.sv
tb_avl_mem.sv
tb_i2c_avl_bridge.sv

/* tb_avl_mem.sv */
`timescale 1ns/1ps
`include "i2c_avl_defs.svh"

module tb_avl_mem (
  input  logic                   clk,
  input  logic                   arst_n,
  input  i2c_avl_pkg::avl_cmd_t  cmd,
  input  logic [3:0]             stall,   // waitrequest cycles before accept
  input  logic [4:0]             lat,     // extra cycles before readdatavalid
  output i2c_avl_pkg::avl_data_t readdata,
  output logic                   readdatavalid,
  output logic                   waitrequest,
  output int                     wr_count,
  output int                     rd_count
);

  logic [7:0] mem [1024];
  logic [3:0] wait_cnt;
  logic [4:0] lat_cnt;
  logic       rd_pend;
  logic [7:0] rd_word;
  logic       accept;

  assign waitrequest = (cmd.read | cmd.write) & (wait_cnt < stall);
  assign accept      = (cmd.read | cmd.write) & ~waitrequest;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 1024; i++) begin
        mem[i] <= 8'(i * 5) ^ 8'(i >> 6);   // every address bit shows up
      end
      wait_cnt      <= '0;
      lat_cnt       <= '0;
      rd_pend       <= 1'b0;
      rd_word       <= '0;
      readdata      <= '0;
      readdatavalid <= 1'b0;
      wr_count      <= 0;
      rd_count      <= 0;
    end else begin
      readdatavalid <= 1'b0;
      if (waitrequest) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
      if (accept) begin
        wait_cnt <= '0;
        if (cmd.write) begin
          wr_count <= wr_count + 1;
          for (int b = 0; b < `AVL_BEW; b++) begin
            if (cmd.byteenable[b]) begin
              mem[{cmd.address[9:2], 2'(b)}] <= cmd.writedata[8*b +: 8];
            end
          end
        end else begin
          rd_count <= rd_count + 1;
          rd_pend  <= 1'b1;
          lat_cnt  <= lat;
          rd_word  <= cmd.address[9:2];
        end
      end
      if (rd_pend) begin
        if (lat_cnt == '0) begin
          rd_pend       <= 1'b0;
          readdatavalid <= 1'b1;
          readdata      <= {mem[{rd_word, 2'd3}], mem[{rd_word, 2'd2}],
                            mem[{rd_word, 2'd1}], mem[{rd_word, 2'd0}]};
        end else begin
          lat_cnt <= lat_cnt - 1'b1;
        end
      end
    end
  end

endmodule

/* tb_i2c_avl_bridge.sv */
`timescale 1ns/1ps
`include "i2c_avl_defs.svh"

module tb_i2c_avl_bridge;

  localparam int HALF     = 40;   // scl half period in clk cycles
  localparam int N_TESTS  = 6;
  localparam int N_BYTES  = 12;
  localparam int WDOG_NS  = N_TESTS * N_BYTES * 20 * 2 * HALF * 10;

  logic                   clk;
  logic                   arst_n;
  logic                   scl_pull;   // 1 pulls low from the master side
  logic                   sda_pull;
  logic                   scl;
  logic                   sda;
  logic                   i2c_data_oe;
  logic                   i2c_clk_oe;
  i2c_avl_pkg::avl_cmd_t  cmd;
  i2c_avl_pkg::avl_addr_t address;
  logic                   read;
  logic                   write;
  i2c_avl_pkg::avl_data_t writedata;
  i2c_avl_pkg::avl_be_t   byteenable;
  i2c_avl_pkg::avl_data_t readdata;
  logic                   readdatavalid;
  logic                   waitrequest;
  logic [3:0]             stall;
  logic [4:0]             lat;
  logic                   stress;
  logic [31:0]            lfsr;
  int                     wr_count;
  int                     rd_count;
  int                     errors;
  int                     checks;
  string                  test_name;

  assign scl = ~(scl_pull | i2c_clk_oe);   // wired-and bus
  assign sda = ~(sda_pull | i2c_data_oe);

  always_comb begin
    cmd.address    = address;
    cmd.read       = read;
    cmd.write      = write;
    cmd.writedata  = writedata;
    cmd.byteenable = byteenable;
  end

  i2c_avl_bridge u_i2c_avl_bridge (
    .clk (clk), .arst_n (arst_n),
    .i2c_data_in (sda), .i2c_clk_in (scl),
    .i2c_data_oe (i2c_data_oe), .i2c_clk_oe (i2c_clk_oe),
    .address (address), .read (read), .write (write),
    .writedata (writedata), .byteenable (byteenable),
    .readdata (readdata), .readdatavalid (readdatavalid), .waitrequest (waitrequest)
  );

  tb_avl_mem u_mem (
    .clk (clk), .arst_n (arst_n), .cmd (cmd), .stall (stall), .lat (lat),
    .readdata (readdata), .readdatavalid (readdatavalid), .waitrequest (waitrequest),
    .wr_count (wr_count), .rd_count (rd_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // random bus stalls in the stress test only
  always @(posedge clk) begin
    if (stress) begin
      stall <= 4'(take_bits(4));
      lat   <= 5'(take_bits(5) % 31);
    end else begin
      stall <= '0;
      lat   <= '0;
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic scl_release;
    scl_pull <= 1'b0;
    @(posedge clk);
    while (!scl) @(posedge clk);   // slave may stretch
  endtask

  task automatic send_bit(input logic b);
    sda_pull <= ~b;
    wait_cycles(HALF / 2);
    scl_release();
    wait_cycles(HALF);
    scl_pull <= 1'b1;
    wait_cycles(HALF / 2);
  endtask

  task automatic recv_bit(output logic b);
    sda_pull <= 1'b0;
    wait_cycles(HALF / 2);
    scl_release();
    wait_cycles(HALF / 2);
    b = sda;
    wait_cycles(HALF / 2);
    scl_pull <= 1'b1;
    wait_cycles(HALF / 2);
  endtask

  // plain or repeated start that leaves scl low
  task automatic i2c_start;
    sda_pull <= 1'b0;
    wait_cycles(HALF / 2);
    scl_release();
    wait_cycles(HALF / 2);
    sda_pull <= 1'b1;
    wait_cycles(HALF / 2);
    scl_pull <= 1'b1;
    wait_cycles(HALF / 2);
  endtask

  task automatic i2c_stop;
    sda_pull <= 1'b1;
    wait_cycles(HALF / 2);
    scl_release();
    wait_cycles(HALF / 2);
    sda_pull <= 1'b0;
    wait_cycles(HALF);
  endtask

  task automatic send_byte(input logic [7:0] b, output logic ack);
    logic a;
    for (int i = 7; i >= 0; i--) begin
      send_bit(b[i]);
    end
    recv_bit(a);
    ack = ~a;
  endtask

  task automatic write_byte(input logic [7:0] b);
    logic ack;
    send_byte(b, ack);
    if (!ack) begin
      errors++;
      $display("%s: the slave did not acknowledge byte %02h", test_name, b);
    end
  endtask

  task automatic recv_byte(input logic ack, output logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      recv_bit(b[i]);
    end
    send_bit(~ack);
  endtask

  function automatic logic [7:0] burst_byte(input logic [7:0] seed, input int i);
    return seed + 8'(i * 29);
  endfunction

  task automatic write_burst(input logic [15:0] a, input int n, input logic [7:0] seed);
    int w0;
    w0 = wr_count;
    i2c_start();
    write_byte({`I2C_SLAVE_ADDR, 1'b0});
    write_byte(a[15:8]);
    write_byte(a[7:0]);
    for (int i = 0; i < n; i++) begin
      write_byte(burst_byte(seed, i));
    end
    i2c_stop();
    for (int i = 0; i < n; i++) begin
      check("mem byte", burst_byte(seed, i), u_mem.mem[10'(a + 16'(i))]);
    end
    check("write count", n, wr_count - w0);
  endtask

  task automatic pointer_read(input logic [15:0] a, input int n);
    int         r0;
    logic [7:0] b;
    r0 = rd_count;
    i2c_start();
    write_byte({`I2C_SLAVE_ADDR, 1'b0});
    write_byte(a[15:8]);
    write_byte(a[7:0]);
    i2c_start();
    write_byte({`I2C_SLAVE_ADDR, 1'b1});
    for (int i = 0; i < n; i++) begin
      recv_byte(i != n - 1, b);   // nack on the last one
      check("read byte", u_mem.mem[10'(a + 16'(i))], b);
    end
    i2c_stop();
    check("read count", n, rd_count - r0);
  endtask

  task automatic test_reset;
    test_name = "reset";
    check("i2c_data_oe", 0, i2c_data_oe);
    check("i2c_clk_oe", 0, i2c_clk_oe);
    check("read", 0, read);
    check("write", 0, write);
  endtask

  task automatic test_wrong_addr;
    logic ack;
    int   w0;
    int   r0;
    test_name = "wrong_addr";
    w0 = wr_count;
    r0 = rd_count;
    i2c_start();
    send_byte({7'h2a, 1'b0}, ack);
    check("ack", 0, ack);
    // pointer and data that a wrongly selected slave would turn into a write
    send_byte(8'h00, ack);
    check("pointer ack", 0, ack);
    send_byte(8'h10, ack);
    check("pointer ack", 0, ack);
    send_byte(8'ha5, ack);
    check("data ack", 0, ack);
    i2c_stop();
    check("bus strobes", 0, (wr_count - w0) + (rd_count - r0));
  endtask

  task automatic test_abandoned;
    test_name = "abandoned";
    i2c_start();
    write_byte({`I2C_SLAVE_ADDR, 1'b0});
    write_byte(8'h03);
    i2c_stop();
    write_burst(16'h0321, 3, 8'h90);
  endtask

  initial begin
    arst_n    = 1'b0;
    scl_pull  = 1'b0;
    sda_pull  = 1'b0;
    stall     = '0;
    lat       = '0;
    stress    = 1'b0;
    lfsr      = 32'hcae86a64;
    errors    = 0;
    checks    = 0;
    test_name = "none";
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    wait_cycles(5);
    test_reset();
    test_name = "write_burst";
    write_burst(16'h0102, 6, 8'h5a);
    test_name = "pointer_read";
    pointer_read(16'h0101, 6);
    test_wrong_addr();
    test_name = "stall";
    stress <= 1'b1;
    write_burst(16'h0200, 8, 8'hc3);
    pointer_read(16'h01fe, 8);
    stress <= 1'b0;
    test_abandoned();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(WDOG_NS);
    $display("watchdog expired in test %s, the run did not finish in time", test_name);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
